//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_bflyNet
FILELIST = build.f

SRCS = $(shell grep -v '^+' $(FILELIST))
BIN  = obj_dir/V$(TOP)
LOG  = sim.log

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then exit 1; fi
	@grep -q "=== PASS ===" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- bflyNet.sv
`timescale 1ns/10ps

module bflyNet import bflyPkg::*; (
  input  logic                   clk_i,
  input  logic                   arstN_i,
  // master side
  input  logic    [NumPorts-1:0] req_i,
  output logic    [NumPorts-1:0] gnt_o,
  input  portIdxT [NumPorts-1:0] add_i,
  input  dataT    [NumPorts-1:0] wdata_i,
  output logic    [NumPorts-1:0] vld_o,
  input  logic    [NumPorts-1:0] rdy_i,
  output dataT    [NumPorts-1:0] rdata_o,
  // target side
  output logic    [NumPorts-1:0] req_o,
  output portIdxT [NumPorts-1:0] idx_o,
  input  logic    [NumPorts-1:0] gnt_i,
  output dataT    [NumPorts-1:0] wdata_o,
  input  logic    [NumPorts-1:0] vld_i,
  output logic    [NumPorts-1:0] rdy_o,
  input  portIdxT [NumPorts-1:0] idx_i,
  input  dataT    [NumPorts-1:0] rdata_i
);

  prioT                    prio;
  prioT                    prioRet;
  logic                    advance;
  reqFlitT  [NumPorts-1:0] reqFlitMst;
  respFlitT [NumPorts-1:0] respFlitTgt;

  // priorities move on with every accepted request
  assign advance = |(req_o & gnt_i);

  bflyPrioLfsr uPrio (
    .clk_i    (clk_i),
    .arstN_i  (arstN_i),
    .advance_i(advance),
    .prio_o   (prio),
    .prioRet_o(prioRet)
  );

  // each stage keeps its own lane signals and reads its neighbours directly
  for (genvar s = 0; s < NumStages; s++) begin : genStage
    logic     [NumPorts-1:0] reqIn;
    logic     [NumPorts-1:0] reqOut;
    logic     [NumPorts-1:0] gntIn;
    logic     [NumPorts-1:0] gntOut;
    reqFlitT  [NumPorts-1:0] reqFlitIn;
    reqFlitT  [NumPorts-1:0] reqFlitOut;
    logic     [NumPorts-1:0] vldIn;
    logic     [NumPorts-1:0] vldOut;
    logic     [NumPorts-1:0] rdyIn;
    logic     [NumPorts-1:0] rdyOut;
    respFlitT [NumPorts-1:0] respFlitIn;
    respFlitT [NumPorts-1:0] respFlitOut;

    // master side of the stage
    if (s == 0) begin : genHead
      assign reqIn     = req_i;
      assign reqFlitIn = reqFlitMst;
      assign rdyIn     = rdy_i;
    end else begin : genLink
      assign reqIn     = genStage[s-1].reqOut;
      assign reqFlitIn = genStage[s-1].reqFlitOut;
      assign rdyIn     = genStage[s-1].rdyOut;
    end

    // target side of the stage
    if (s == NumStages - 1) begin : genTail
      assign gntIn      = gnt_i;
      assign vldIn      = vld_i;
      assign respFlitIn = respFlitTgt;
    end else begin : genNext
      assign gntIn      = genStage[s+1].gntOut;
      assign vldIn      = genStage[s+1].vldOut;
      assign respFlitIn = genStage[s+1].respFlitOut;
    end

    bflyStage #(
      .StageIdx(s)
    ) uStage (
      .reqIn_i      (reqIn),
      .reqFlitIn_i  (reqFlitIn),
      .gntOut_o     (gntOut),
      .reqOut_o     (reqOut),
      .reqFlitOut_o (reqFlitOut),
      .gntIn_i      (gntIn),
      .vldIn_i      (vldIn),
      .respFlitIn_i (respFlitIn),
      .rdyOut_o     (rdyOut),
      .vldOut_o     (vldOut),
      .respFlitOut_o(respFlitOut),
      .rdyIn_i      (rdyIn),
      .prio_i       (prio[s]),
      .prioRet_i    (prioRet[s])
    );
  end

  assign gnt_o = genStage[0].gntOut;
  assign vld_o = genStage[0].vldOut;
  assign req_o = genStage[NumStages-1].reqOut;
  assign rdy_o = genStage[NumStages-1].rdyOut;

  // masters tag requests with their own index, lane t ends at target t
  for (genvar p = 0; p < NumPorts; p++) begin : genPorts
    assign reqFlitMst[p]  = '{addr: add_i[p], idx: portIdxT'(p), wdata: wdata_i[p]};
    assign respFlitTgt[p] = '{idx: idx_i[p], rdata: rdata_i[p]};
    assign idx_o[p]       = genStage[NumStages-1].reqFlitOut[p].idx;
    assign wdata_o[p]     = genStage[NumStages-1].reqFlitOut[p].wdata;
    assign rdata_o[p]     = genStage[0].respFlitOut[p].rdata;
  end

endmodule

//--- bflyNet_chk.sv
`timescale 1ns/10ps

module bflyNet_chk import bflyPkg::*; (
  input logic                   clk_i,
  input logic                   arstN_i,
  input logic    [NumPorts-1:0] req_i,
  input logic    [NumPorts-1:0] gnt_o,
  input portIdxT [NumPorts-1:0] add_i,
  input logic    [NumPorts-1:0] req_o,
  input portIdxT [NumPorts-1:0] idx_o,
  input logic    [NumPorts-1:0] vld_o,
  input logic    [NumPorts-1:0] vld_i,
  input portIdxT [NumPorts-1:0] idx_i
);

  // masters that some valid target response points at
  logic [NumPorts-1:0] respSrc;

  always_comb begin
    respSrc = '0;
    for (int t = 0; t < NumPorts; t++) begin
      if (vld_i[t]) respSrc[idx_i[t]] = 1'b1;
    end
  end

  for (genvar p = 0; p < NumPorts; p++) begin : genProps
    gntNeedsReq: assert property (@(posedge clk_i) disable iff (!arstN_i)
      gnt_o[p] |-> req_i[p])
      else $error("grant at master %0d without request", p);

    reqRoutedRight: assert property (@(posedge clk_i) disable iff (!arstN_i)
      req_o[p] |-> (add_i[idx_o[p]] == portIdxT'(p)))
      else $error("target %0d got a request addressed elsewhere", p);

    vldHasSource: assert property (@(posedge clk_i) disable iff (!arstN_i)
      vld_o[p] |-> respSrc[p])
      else $error("master %0d sees a response nobody sent", p);
  end

endmodule

bind bflyNet bflyNet_chk uChk (.*);

//--- bflyPkg.sv
package bflyPkg;

  // network size, one master and one target per lane
  localparam int unsigned NumPorts  = 8;
  localparam int unsigned PortWidth = 3;
  // one 2x2 switchbox stage per address bit
  localparam int unsigned NumStages = 3;
  localparam int unsigned DataWidth = 32;

  // priority source
  localparam int unsigned LfsrWidth = 16;
  localparam logic [LfsrWidth-1:0] LfsrSeed = 16'hACE1;
  // taps of x^16 + x^14 + x^13 + x^11 for a right shifting galois register
  localparam logic [LfsrWidth-1:0] LfsrTaps = 16'hB400;

  // bank address toward the targets, master index back toward the masters
  typedef logic [PortWidth-1:0] portIdxT;

  typedef logic [DataWidth-1:0] dataT;

  // one tie breaker bit per stage
  typedef logic [NumStages-1:0] prioT;

  // request on its way to a bank
  typedef struct packed {
    portIdxT addr;
    portIdxT idx;
    dataT    wdata;
  } reqFlitT;

  // response on its way back, steered by the index of the requesting master
  typedef struct packed {
    portIdxT idx;
    dataT    rdata;
  } respFlitT;

endpackage

//--- bflyPrioLfsr.sv
`timescale 1ns/10ps

module bflyPrioLfsr import bflyPkg::*; (
  input  logic clk_i,
  input  logic arstN_i,
  // high in cycles where some target accepts a request
  input  logic advance_i,
  output prioT prio_o,
  output prioT prioRet_o
);

  logic [LfsrWidth-1:0] lfsrQ;
  logic [LfsrWidth-1:0] lfsrD;

  // right shift with the dropped bit folded back into the tap positions
  assign lfsrD = lfsrQ[0] ? ((lfsrQ >> 1) ^ LfsrTaps) : (lfsrQ >> 1);

  always_ff @(posedge clk_i or negedge arstN_i) begin
    if (!arstN_i) begin
      lfsrQ <= LfsrSeed;
    end else if (advance_i) begin
      lfsrQ <= lfsrD;
    end
  end

  // request ties use the low bits, response ties the next group up
  assign prio_o    = lfsrQ[NumStages-1:0];
  assign prioRet_o = lfsrQ[2*NumStages-1:NumStages];

endmodule

//--- bflyStage.sv
`timescale 1ns/10ps

module bflyStage import bflyPkg::*; #(
  parameter int unsigned StageIdx = 0
) (
  // request path, master side
  input  logic     [NumPorts-1:0] reqIn_i,
  input  reqFlitT  [NumPorts-1:0] reqFlitIn_i,
  output logic     [NumPorts-1:0] gntOut_o,
  // request path, target side
  output logic     [NumPorts-1:0] reqOut_o,
  output reqFlitT  [NumPorts-1:0] reqFlitOut_o,
  input  logic     [NumPorts-1:0] gntIn_i,
  // response path, target side
  input  logic     [NumPorts-1:0] vldIn_i,
  input  respFlitT [NumPorts-1:0] respFlitIn_i,
  output logic     [NumPorts-1:0] rdyOut_o,
  // response path, master side
  output logic     [NumPorts-1:0] vldOut_o,
  output respFlitT [NumPorts-1:0] respFlitOut_o,
  input  logic     [NumPorts-1:0] rdyIn_i,
  // shared by every switchbox of the stage
  input  logic                    prio_i,
  input  logic                    prioRet_i
);

  // first stage looks at the address msb, the last one at the lsb
  localparam int unsigned StageBit = PortWidth - 1 - StageIdx;
  localparam int unsigned Weight   = 1 << StageBit;

  for (genvar k = 0; k < NumPorts / 2; k++) begin : genSwitch
    // the two lanes of a switchbox differ only in the stage bit
    localparam int unsigned Lo = (k / Weight) * 2 * Weight + (k % Weight);
    localparam int unsigned Hi = Lo + Weight;

    // port 0 is the lower lane and port 1 the upper lane on both sides
    bflySwitch #(
      .StageBit(StageBit)
    ) uSwitch (
      .reqIn_i      ({reqIn_i[Hi], reqIn_i[Lo]}),
      .reqFlitIn_i  ({reqFlitIn_i[Hi], reqFlitIn_i[Lo]}),
      .gntOut_o     ({gntOut_o[Hi], gntOut_o[Lo]}),
      .reqOut_o     ({reqOut_o[Hi], reqOut_o[Lo]}),
      .reqFlitOut_o ({reqFlitOut_o[Hi], reqFlitOut_o[Lo]}),
      .gntIn_i      ({gntIn_i[Hi], gntIn_i[Lo]}),
      .vldIn_i      ({vldIn_i[Hi], vldIn_i[Lo]}),
      .respFlitIn_i ({respFlitIn_i[Hi], respFlitIn_i[Lo]}),
      .rdyOut_o     ({rdyOut_o[Hi], rdyOut_o[Lo]}),
      .vldOut_o     ({vldOut_o[Hi], vldOut_o[Lo]}),
      .respFlitOut_o({respFlitOut_o[Hi], respFlitOut_o[Lo]}),
      .rdyIn_i      ({rdyIn_i[Hi], rdyIn_i[Lo]}),
      .prio_i       (prio_i),
      .prioRet_i    (prioRet_i)
    );
  end

endmodule

//--- bflySwitch.sv
`timescale 1ns/10ps

module bflySwitch import bflyPkg::*; #(
  parameter int unsigned StageBit = 0
) (
  // requests from the master side
  input  logic     [1:0] reqIn_i,
  input  reqFlitT  [1:0] reqFlitIn_i,
  output logic     [1:0] gntOut_o,
  // requests toward the target side
  output logic     [1:0] reqOut_o,
  output reqFlitT  [1:0] reqFlitOut_o,
  input  logic     [1:0] gntIn_i,
  // responses from the target side
  input  logic     [1:0] vldIn_i,
  input  respFlitT [1:0] respFlitIn_i,
  output logic     [1:0] rdyOut_o,
  // responses toward the master side
  output logic     [1:0] vldOut_o,
  output respFlitT [1:0] respFlitOut_o,
  input  logic     [1:0] rdyIn_i,
  // value names the input that wins a tie
  input  logic           prio_i,
  input  logic           prioRet_i
);

  // output chosen by each input
  logic [1:0]      reqSel;
  logic [1:0]      respSel;
  // contenders per output, indexed [output][input]
  logic [1:0][1:0] reqWant;
  logic [1:0][1:0] respWant;
  // winning input per output
  logic [1:0]      reqWin;
  logic [1:0]      respWin;

  // a lone contender wins outright, two of them defer to the priority bit
  function automatic logic pickWinner(logic [1:0] want, logic prio);
    return (&want) ? prio : want[1];
  endfunction

  // request steering by the address bit of this stage
  always_comb begin
    for (int o = 0; o < 2; o++) begin
      for (int i = 0; i < 2; i++) begin
        reqSel[i]     = reqFlitIn_i[i].addr[StageBit];
        reqWant[o][i] = reqIn_i[i] && (reqSel[i] == 1'(o));
      end
      reqWin[o]       = pickWinner(reqWant[o], prio_i);
      reqOut_o[o]     = |reqWant[o];
      reqFlitOut_o[o] = reqFlitIn_i[reqWin[o]];
    end
  end

  // response steering by the matching bit of the master index
  always_comb begin
    for (int o = 0; o < 2; o++) begin
      for (int i = 0; i < 2; i++) begin
        respSel[i]     = respFlitIn_i[i].idx[StageBit];
        respWant[o][i] = vldIn_i[i] && (respSel[i] == 1'(o));
      end
      respWin[o]       = pickWinner(respWant[o], prioRet_i);
      vldOut_o[o]      = |respWant[o];
      respFlitOut_o[o] = respFlitIn_i[respWin[o]];
    end
  end

  // grant goes back only to the request that owns its output
  always_comb begin
    for (int i = 0; i < 2; i++) begin
      gntOut_o[i] = reqIn_i[i] && gntIn_i[reqSel[i]] && (reqWin[reqSel[i]] == 1'(i));
    end
  end

  // ready of the chosen master side port returns to the winning response
  always_comb begin
    for (int i = 0; i < 2; i++) begin
      rdyOut_o[i] = vldIn_i[i] && rdyIn_i[respSel[i]] && (respWin[respSel[i]] == 1'(i));
    end
  end

endmodule

//--- build.f
bflyPkg.sv
bflySwitch.sv
bflyStage.sv
bflyPrioLfsr.sv
bflyNet.sv
bflyNet_chk.sv
tb_bflyNet.sv

//--- tb_bflyNet.sv
`timescale 1ns/10ps

module tb_bflyNet import bflyPkg::*; ();

  // reset, test lengths and slack in clock cycles
  localparam int TotalCycles = 3 + 16 + 2 + 200 + 70 + 24 + 6;
  localparam int ClkPeriod   = 20;

  logic clk;
  logic arstN;
  logic    [NumPorts-1:0] reqI;
  logic    [NumPorts-1:0] gntO;
  logic    [NumPorts-1:0] vldO;
  logic    [NumPorts-1:0] rdyI;
  logic    [NumPorts-1:0] reqO;
  logic    [NumPorts-1:0] gntI;
  logic    [NumPorts-1:0] vldI;
  logic    [NumPorts-1:0] rdyO;
  portIdxT [NumPorts-1:0] addI;
  portIdxT [NumPorts-1:0] idxO;
  portIdxT [NumPorts-1:0] idxI;
  dataT    [NumPorts-1:0] wdataI;
  dataT    [NumPorts-1:0] rdataO;
  dataT    [NumPorts-1:0] wdataO;
  dataT    [NumPorts-1:0] rdataI;

  // target memory with one word per bank
  dataT mem [NumPorts];
  logic [31:0] rngState;
  logic checkEn;
  int errCount;
  int testCount;
  int testFail;
  int testStart;

  // compare process scratch
  logic [NumPorts-1:0] tgtEmpty;
  logic [NumPorts-1:0][NumPorts-1:0] tgtSet;
  logic expGnt;
  int srcCnt;
  int srcT;

  bflyNet u_dut (
    .clk_i(clk), .arstN_i(arstN),
    .req_i(reqI), .gnt_o(gntO), .add_i(addI), .wdata_i(wdataI),
    .vld_o(vldO), .rdy_i(rdyI), .rdata_o(rdataO),
    .req_o(reqO), .idx_o(idxO), .gnt_i(gntI), .wdata_o(wdataO),
    .vld_i(vldI), .rdy_o(rdyO), .idx_i(idxI), .rdata_i(rdataI)
  );

  always #(ClkPeriod / 2) clk = ~clk;

  function automatic logic [31:0] xorshift32(logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // which masters address each target, and whether that set is empty
  function automatic void refRoute(input logic [NumPorts-1:0] req,
                                   input portIdxT [NumPorts-1:0] add,
                                   output logic [NumPorts-1:0] empty,
                                   output logic [NumPorts-1:0][NumPorts-1:0] members);
    members = '0;
    for (int m = 0; m < NumPorts; m++) begin
      if (req[m]) members[add[m]][m] = 1'b1;
    end
    for (int t = 0; t < NumPorts; t++) empty[t] = (members[t] == '0);
  endfunction

  task automatic reportMismatch(string sig, int idx, logic [31:0] exp, logic [31:0] got);
    $display("CHECK FAILED @%0t %s[%0d] expected %0h got %0h", $time, sig, idx, exp, got);
    errCount++;
  endtask

  task automatic reportProblem(string what);
    $display("ERROR @%0t %s", $time, what);
    errCount++;
  endtask

  task automatic endTest(string name);
    string verdict;
    testCount++;
    if (errCount != testStart) begin
      testFail++;
      verdict = "FAILED";
    end else begin
      verdict = "ok";
    end
    $display("test %s %s (%0d errors)", name, verdict, errCount - testStart);
    testStart = errCount;
  endtask

  task automatic idleInputs();
    reqI = '0;
    vldI = '0;
    rdyI = '1;
    gntI = '1;
  endtask

  // bank writes on every accepted request
  always @(posedge clk) begin
    for (int t = 0; t < NumPorts; t++) begin
      if (reqO[t] && gntI[t]) mem[t] <= wdataO[t];
    end
  end

  // compare process
  always @(posedge clk) begin
    if (checkEn) begin
      refRoute(reqI, addI, tgtEmpty, tgtSet);
      for (int t = 0; t < NumPorts; t++) begin
        if (tgtEmpty[t]) begin
          assert (!reqO[t]) else reportMismatch("req_o", t, 0, 32'(reqO[t]));
        end else if (reqO[t]) begin
          assert (tgtSet[t][idxO[t]])
          else reportProblem($sformatf("target %0d served a master not addressing it", t));
          assert (wdataO[t] == wdataI[idxO[t]])
          else reportMismatch("wdata_o", t, wdataI[idxO[t]], wdataO[t]);
        end
      end
      if (|reqI) begin
        assert (|reqO) else reportProblem("requests pending but no target sees one");
      end
      for (int m = 0; m < NumPorts; m++) begin
        expGnt = 1'b0;
        srcCnt = 0;
        srcT = 0;
        for (int t = 0; t < NumPorts; t++) begin
          if (reqO[t] && gntI[t] && idxO[t] == portIdxT'(m)) expGnt = 1'b1;
          if (vldI[t] && idxI[t] == portIdxT'(m)) begin
            srcCnt++;
            srcT = t;
          end
        end
        assert (gntO[m] == expGnt)
        else reportMismatch("gnt_o", m, 32'(expGnt), 32'(gntO[m]));
        if (srcCnt == 0) begin
          assert (!vldO[m]) else reportMismatch("vld_o", m, 0, 32'(vldO[m]));
        end else if (srcCnt == 1) begin
          assert (vldO[m]) else reportMismatch("vld_o", m, 1, 32'(vldO[m]));
          assert (rdataO[m] == rdataI[srcT])
          else reportMismatch("rdata_o", m, rdataI[srcT], rdataO[m]);
          assert (rdyO[srcT] == rdyI[m])
          else reportMismatch("rdy_o", srcT, 32'(rdyI[m]), 32'(rdyO[srcT]));
        end
      end
      for (int t = 0; t < NumPorts; t++) begin
        if (!vldI[t]) begin
          assert (!rdyO[t]) else reportMismatch("rdy_o", t, 0, 32'(rdyO[t]));
        end
      end
    end
  end

  // watchdog
  initial begin
    #(TotalCycles * ClkPeriod + 50 * ClkPeriod);
    $display("ERROR run did not finish in time");
    $display("=== FAIL ===");
    $finish;
  end

  initial begin
    logic [1:0] pending;
    int cyc;
    int m;
    clk = 1'b0;
    arstN = 1'b0;
    checkEn = 1'b0;
    rngState = 32'h2d28_9248;
    errCount = 0;
    testCount = 0;
    testFail = 0;
    testStart = 0;
    addI = '0;
    wdataI = '0;
    idxI = '0;
    rdataI = '0;
    idleInputs();
    repeat (3) @(negedge clk);
    arstN = 1'b1;
    checkEn = 1'b1;

    // single master sweeps all targets
    for (int t = 0; t < NumPorts; t++) begin
      @(negedge clk);
      rngState = xorshift32(rngState);
      m = rngState % NumPorts;
      idleInputs();
      reqI[m] = 1'b1;
      addI[m] = portIdxT'(t);
      wdataI[m] = rngState;
      @(posedge clk);
      assert (reqO[t] && idxO[t] == portIdxT'(m) && gntO[m])
      else reportProblem($sformatf("master %0d not delivered to target %0d", m, t));
    end
    @(negedge clk);
    idleInputs();
    endTest("single");

    // identity pattern has no internal conflicts
    @(negedge clk);
    reqI = '1;
    for (int p = 0; p < NumPorts; p++) begin
      addI[p] = portIdxT'(p);
      wdataI[p] = 32'h1000_0000 + p;
    end
    @(posedge clk);
    assert (reqO == '1) else reportMismatch("req_o", 0, 32'hff, 32'(reqO));
    assert (gntO == '1) else reportMismatch("gnt_o", 0, 32'hff, 32'(gntO));
    @(negedge clk);
    idleInputs();
    endTest("identity");

    // random request sets with random target grants
    for (int c = 0; c < 200; c++) begin
      @(negedge clk);
      rngState = xorshift32(rngState);
      reqI = rngState[7:0];
      gntI = rngState[15:8] | rngState[23:16];
      for (int p = 0; p < NumPorts; p++) begin
        rngState = xorshift32(rngState);
        addI[p] = rngState[2:0];
        wdataI[p] = rngState;
      end
    end
    @(negedge clk);
    idleInputs();
    endTest("random");

    // two masters contend for one bank until both are served
    @(negedge clk);
    addI[1] = 3'd2;
    addI[6] = 3'd2;
    wdataI[1] = 32'hAAAA_0001;
    wdataI[6] = 32'hBBBB_0006;
    pending = 2'b11;
    cyc = 0;
    while (pending != 2'b00 && cyc < 64) begin
      @(negedge clk);
      reqI[1] = pending[0];
      reqI[6] = pending[1];
      @(posedge clk);
      if (gntO[1]) pending[0] = 1'b0;
      if (gntO[6]) pending[1] = 1'b0;
      cyc++;
    end
    assert (pending == 2'b00) else reportProblem("contending masters not both granted in 64 cycles");
    @(negedge clk);
    idleInputs();
    endTest("contention");

    // each target responds to a random master while ready toggles
    for (int t = 0; t < NumPorts; t++) begin
      rngState = xorshift32(rngState);
      m = rngState % NumPorts;
      for (int r = 0; r < 3; r++) begin
        @(negedge clk);
        idleInputs();
        vldI[t] = 1'b1;
        idxI[t] = portIdxT'(m);
        rdataI[t] = mem[t] ^ {29'd0, 3'(r)};
        rdyI[m] = (r != 1);
      end
    end
    @(negedge clk);
    idleInputs();
    endTest("response");

    // back-pressure on both paths
    @(negedge clk);
    reqI[3] = 1'b1;
    addI[3] = 3'd5;
    gntI[5] = 1'b0;
    vldI[2] = 1'b1;
    idxI[2] = 3'd6;
    rdataI[2] = 32'hDEAD_BEEF;
    rdyI[6] = 1'b0;
    repeat (2) begin
      @(posedge clk);
      assert (!gntO[3]) else reportMismatch("gnt_o", 3, 0, 32'(gntO[3]));
      assert (!rdyO[2]) else reportMismatch("rdy_o", 2, 0, 32'(rdyO[2]));
    end
    @(negedge clk);
    idleInputs();
    endTest("backpressure");

    @(negedge clk);
    checkEn = 1'b0;
    $display("tests %0d, failed %0d, errors %0d", testCount, testFail, errCount);
    if (errCount == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule
